// File: common/axil_pkg.sv
// Single-beat AXI-Lite only; no burst, no byte strobes, no prot, slave answers OKAY only
`default_nettype none

package axil_pkg;

  localparam int axil_addr_w = 32;
  localparam int axil_data_w = 32;

  // ------------------------------
  // Response code and write FSM
  // ------------------------------
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_e;

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_e;

  // ------------------------------
  // Channel bundles
  // ------------------------------
  // Master to slave, 101 bits
  typedef struct packed {
    logic                   awvalid;
    logic [axil_addr_w-1:0] awaddr;
    logic                   wvalid;
    logic [axil_data_w-1:0] wdata;
    logic                   bready;
    logic                   arvalid;
    logic [axil_addr_w-1:0] araddr;
    logic                   rready;
  } axil_req_t;

  // Slave to master, 41 bits
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    axil_resp_e             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [axil_data_w-1:0] rdata;
    axil_resp_e             rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

// File: common/regmap_pkg.sv
// Register map uses full 32-bit word addresses; compile after axil_pkg, counter fields are fixed widths
`default_nettype none

package regmap_pkg;

  // ------------------------------
  // Register addresses
  // ------------------------------
  localparam logic [axil_pkg::axil_addr_w-1:0] addr_hello      = 32'h0000_0500;
  localparam logic [axil_pkg::axil_addr_w-1:0] addr_vled       = 32'h0000_0504;
  localparam logic [axil_pkg::axil_addr_w-1:0] addr_cnt_ctrl   = 32'h0000_0510;
  localparam logic [axil_pkg::axil_addr_w-1:0] addr_cnt_tick   = 32'h0000_0514;
  localparam logic [axil_pkg::axil_addr_w-1:0] addr_cnt_load   = 32'h0000_0518;
  localparam logic [axil_pkg::axil_addr_w-1:0] addr_cnt_mark   = 32'h0000_051C;
  localparam logic [axil_pkg::axil_addr_w-1:0] addr_cnt_status = 32'h0000_0520;

  // Returned for any address not in the map
  localparam logic [axil_pkg::axil_data_w-1:0] unimpl_value = 32'hDEAD_DEAD;

  // Bit positions in the cnt_ctrl word
  localparam int ctrl_enable_bit  = 0;
  localparam int ctrl_oneshot_bit = 1;
  localparam int ctrl_load_bit    = 2;
  localparam int ctrl_clear_bit   = 3;

  // Counter setup field widths
  localparam int tick_w      = 8;
  localparam int cnt_field_w = 16;

  // ------------------------------
  // Register-side requests
  // ------------------------------
  typedef struct packed {
    logic                            valid;
    logic [axil_pkg::axil_addr_w-1:0] addr;
    logic [axil_pkg::axil_data_w-1:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic                            valid;
    logic [axil_pkg::axil_addr_w-1:0] addr;
  } reg_rd_t;

  // ------------------------------
  // Counter configuration
  // ------------------------------
  typedef enum logic [1:0] {
    cnt_hold,
    cnt_clear,
    cnt_load,
    cnt_run
  } cnt_op_e;

  typedef struct packed {
    cnt_op_e                op;
    logic                   oneshot;
    logic [tick_w-1:0]      tick_value;
    logic [cnt_field_w-1:0] load_value;
    logic [cnt_field_w-1:0] mark_value;
  } cnt_cfg_t;

endpackage

`default_nettype wire

// File: ocl_slave/ocl_slave.sv
// One outstanding write and one outstanding read; aw must come before w, every write is a full word
`default_nettype none
`timescale 1ns/1ps

module ocl_slave (
  input  wire logic                             clk_main_a0,
  input  wire logic                             rst_main_n_sync,
  input  wire axil_pkg::axil_req_t              req,
  output axil_pkg::axil_rsp_t                   rsp,
  output regmap_pkg::reg_wr_t                   wr,
  output regmap_pkg::reg_rd_t                   rd,
  input  wire logic [axil_pkg::axil_data_w-1:0] rd_data
);

  axil_pkg::wr_state_e                  state_q;
  logic [axil_pkg::axil_addr_w-1:0]     wr_addr_q;
  logic                                 aw_fire;
  logic                                 w_fire;

  regmap_pkg::reg_rd_t                  rd_q;
  logic                                 arready_q;
  logic                                 rvalid_q;
  logic [axil_pkg::axil_data_w-1:0]     rdata_q;
  logic                                 ar_fire;

  // ------------------------------
  // Write side
  // ------------------------------
  assign aw_fire = req.awvalid && (state_q == axil_pkg::wr_idle);
  assign w_fire  = req.wvalid && (state_q == axil_pkg::wr_data);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state_q   <= axil_pkg::wr_idle;
      wr_addr_q <= '0;
    end else begin
      case (state_q)
        axil_pkg::wr_idle: begin
          if (aw_fire) begin
            wr_addr_q <= req.awaddr;
            state_q   <= axil_pkg::wr_data;
          end
        end
        axil_pkg::wr_data: begin
          if (w_fire) begin
            state_q <= axil_pkg::wr_resp;
          end
        end
        axil_pkg::wr_resp: begin
          // Response held until the master takes it
          if (req.bready) begin
            state_q <= axil_pkg::wr_idle;
          end
        end
        default: state_q <= axil_pkg::wr_idle;
      endcase
    end
  end

  // Register write happens in the w transfer cycle
  always_comb begin
    wr.valid = w_fire;
    wr.addr  = wr_addr_q;
    wr.data  = req.wdata;
  end

  // ------------------------------
  // Read side
  // ------------------------------
  assign ar_fire = req.arvalid && arready_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_q      <= '0;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rdata_q   <= '0;
    end else begin
      rd_q.valid <= ar_fire;
      if (ar_fire) begin
        rd_q.addr <= req.araddr;
      end
      // Reopen only once the previous response has been taken
      arready_q <= !ar_fire && (rvalid_q ? req.rready : !rd_q.valid);
      if (rd_q.valid) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_data;
      end else if (rvalid_q && req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  assign rd = rd_q;

  // ------------------------------
  // Response bundle
  // ------------------------------
  always_comb begin
    rsp.awready = (state_q == axil_pkg::wr_idle);
    rsp.wready  = w_fire;
    rsp.bvalid  = (state_q == axil_pkg::wr_resp);
    rsp.bresp   = axil_pkg::resp_okay;
    rsp.arready = arready_q;
    rsp.rvalid  = rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = axil_pkg::resp_okay;
  end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// Full-word writes only; load and clear bits self-clear and read as zero, cnt_w must stay below 32
`default_nettype none
`timescale 1ns/1ps

module reg_file #(
  parameter int led_w = 16,
  parameter int cnt_w = 16
) (
  input  wire logic                                 clk_main_a0,
  input  wire logic                                 rst_main_n_sync,
  input  wire regmap_pkg::reg_wr_t                  wr,
  input  wire regmap_pkg::reg_rd_t                  rd,
  output logic [axil_pkg::axil_data_w-1:0]          rd_data,
  output regmap_pkg::cnt_cfg_t                      cfg,
  input  wire logic [cnt_w-1:0]                     count,
  input  wire logic                                 at_mark,
  output logic [led_w-1:0]                          led_shadow
);

  logic [axil_pkg::axil_data_w-1:0]    hello_q;
  logic [axil_pkg::axil_data_w-1:0]    hello_swapped;
  logic                                enable_q;
  logic                                oneshot_q;
  logic                                load_pulse_q;
  logic                                clear_pulse_q;
  logic [regmap_pkg::tick_w-1:0]       tick_q;
  logic [regmap_pkg::cnt_field_w-1:0]  load_q;
  logic [regmap_pkg::cnt_field_w-1:0]  mark_q;
  logic [led_w-1:0]                    led_shadow_q;

  // ------------------------------
  // Register writes
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q       <= '0;
      enable_q      <= 1'b0;
      oneshot_q     <= 1'b0;
      load_pulse_q  <= 1'b0;
      clear_pulse_q <= 1'b0;
      tick_q        <= '0;
      load_q        <= '0;
      mark_q        <= '0;
      led_shadow_q  <= '0;
    end else begin
      // Op pulses last one cycle unless rewritten
      load_pulse_q  <= 1'b0;
      clear_pulse_q <= 1'b0;
      if (wr.valid) begin
        case (wr.addr)
          regmap_pkg::addr_hello: hello_q <= wr.data;
          regmap_pkg::addr_cnt_ctrl: begin
            enable_q      <= wr.data[regmap_pkg::ctrl_enable_bit];
            oneshot_q     <= wr.data[regmap_pkg::ctrl_oneshot_bit];
            load_pulse_q  <= wr.data[regmap_pkg::ctrl_load_bit];
            clear_pulse_q <= wr.data[regmap_pkg::ctrl_clear_bit];
          end
          regmap_pkg::addr_cnt_tick: tick_q <= wr.data[regmap_pkg::tick_w-1:0];
          regmap_pkg::addr_cnt_load: load_q <= wr.data[regmap_pkg::cnt_field_w-1:0];
          regmap_pkg::addr_cnt_mark: mark_q <= wr.data[regmap_pkg::cnt_field_w-1:0];
          default: ;
        endcase
      end
      // LED shadow trails hello-world by one cycle
      led_shadow_q <= hello_q[led_w-1:0];
    end
  end

  assign led_shadow = led_shadow_q;

  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // ------------------------------
  // Counter setup
  // ------------------------------
  always_comb begin
    if (clear_pulse_q) begin
      cfg.op = regmap_pkg::cnt_clear;
    end else if (load_pulse_q) begin
      cfg.op = regmap_pkg::cnt_load;
    end else if (enable_q) begin
      cfg.op = regmap_pkg::cnt_run;
    end else begin
      cfg.op = regmap_pkg::cnt_hold;
    end
    cfg.oneshot    = oneshot_q;
    cfg.tick_value = tick_q;
    cfg.load_value = load_q;
    cfg.mark_value = mark_q;
  end

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    rd_data = '0;
    case (rd.addr)
      regmap_pkg::addr_hello: rd_data = hello_swapped;
      regmap_pkg::addr_vled:  rd_data[led_w-1:0] = led_shadow_q;
      regmap_pkg::addr_cnt_ctrl: begin
        rd_data[regmap_pkg::ctrl_enable_bit]  = enable_q;
        rd_data[regmap_pkg::ctrl_oneshot_bit] = oneshot_q;
      end
      regmap_pkg::addr_cnt_tick:   rd_data[regmap_pkg::tick_w-1:0] = tick_q;
      regmap_pkg::addr_cnt_load:   rd_data[regmap_pkg::cnt_field_w-1:0] = load_q;
      regmap_pkg::addr_cnt_mark:   rd_data[regmap_pkg::cnt_field_w-1:0] = mark_q;
      // Flag sits just above the count
      regmap_pkg::addr_cnt_status: rd_data[cnt_w:0] = {at_mark, count};
      default: rd_data = regmap_pkg::unimpl_value;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/vled_out.sv
// vdip is treated as asynchronous, bits are synchronized independently; sync_stages must be at least 1
`default_nettype none
`timescale 1ns/1ps

module vled_out #(
  parameter int led_w       = 16,
  parameter int sync_stages = 2
) (
  input  wire logic             clk_main_a0,
  input  wire logic             rst_main_n_sync,
  input  wire logic [led_w-1:0] vdip,
  input  wire logic [led_w-1:0] led_shadow,
  output logic      [led_w-1:0] vled
);

  logic [sync_stages-1:0][led_w-1:0] sync_q;
  logic [led_w-1:0]                  vled_q;

  // ------------------------------
  // DIP synchronizer and LED mask
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      sync_q <= '0;
      vled_q <= '0;
    end else begin
      sync_q[0] <= vdip;
      for (int i = 1; i < sync_stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      // Switch off any LED whose DIP is low
      vled_q <= sync_q[sync_stages-1] & led_shadow;
    end
  end

  assign vled = vled_q;

endmodule

`default_nettype wire

// File: tick_counter/tick_counter.sv
// Count rises once per tick_value+1 run cycles; oneshot saturates at all ones; cnt_w at most 16
`default_nettype none
`timescale 1ns/1ps

module tick_counter #(
  parameter int cnt_w = 16
) (
  input  wire logic                 clk_main_a0,
  input  wire logic                 rst_main_n_sync,
  input  wire regmap_pkg::cnt_cfg_t cfg,
  output logic [cnt_w-1:0]          count,
  output logic                      at_mark
);

  logic [regmap_pkg::tick_w-1:0] presc_q;
  logic [cnt_w-1:0]              count_q;
  logic                          at_mark_q;
  logic                          tick;
  logic                          at_max;

  // Prescaler wraps when it reaches the tick value
  assign tick   = (presc_q >= cfg.tick_value);
  assign at_max = (count_q == {cnt_w{1'b1}});

  // ------------------------------
  // Prescaler and main count
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      presc_q <= '0;
      count_q <= '0;
    end else begin
      case (cfg.op)
        regmap_pkg::cnt_clear: begin
          presc_q <= '0;
          count_q <= '0;
        end
        regmap_pkg::cnt_load: begin
          count_q <= cnt_w'(cfg.load_value);
        end
        regmap_pkg::cnt_run: begin
          if (tick) begin
            presc_q <= '0;
            // One-shot holds at the top instead of wrapping
            if (!(cfg.oneshot && at_max)) begin
              count_q <= count_q + 1'b1;
            end
          end else begin
            presc_q <= presc_q + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // ------------------------------
  // Watermark flag
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      at_mark_q <= 1'b0;
    end else begin
      at_mark_q <= (count_q >= cnt_w'(cfg.mark_value));
    end
  end

  assign count   = count_q;
  assign at_mark = at_mark_q;

endmodule

`default_nettype wire

// File: verilog/cl_hello_top.sv
// Reset must arrive already synchronized to clk_main_a0; vdip may be asynchronous
`default_nettype none
`timescale 1ns/1ps

module cl_hello_top #(
  parameter int led_w       = 16,
  parameter int sync_stages = 2,
  parameter int cnt_w       = 16
) (
  input  wire logic                clk_main_a0,
  input  wire logic                rst_main_n_sync,
  input  wire axil_pkg::axil_req_t ocl_req,
  output axil_pkg::axil_rsp_t      ocl_rsp,
  input  wire logic [led_w-1:0]    vdip,
  output logic      [led_w-1:0]    vled
);

  regmap_pkg::reg_wr_t              wr;
  regmap_pkg::reg_rd_t              rd;
  logic [axil_pkg::axil_data_w-1:0] rd_data;
  regmap_pkg::cnt_cfg_t             cfg;
  logic [cnt_w-1:0]                 count;
  logic                             at_mark;
  logic [led_w-1:0]                 led_shadow;

  // ------------------------------
  // Bus slave and registers
  // ------------------------------
  ocl_slave ocl_slave_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (ocl_req),
    .rsp             (ocl_rsp),
    .wr              (wr),
    .rd              (rd),
    .rd_data         (rd_data)
  );

  reg_file #(
    .led_w (led_w),
    .cnt_w (cnt_w)
  ) reg_file_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr              (wr),
    .rd              (rd),
    .rd_data         (rd_data),
    .cfg             (cfg),
    .count           (count),
    .at_mark         (at_mark),
    .led_shadow      (led_shadow)
  );

  // ------------------------------
  // Counter and LED stage
  // ------------------------------
  tick_counter #(
    .cnt_w (cnt_w)
  ) tick_counter_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cfg             (cfg),
    .count           (count),
    .at_mark         (at_mark)
  );

  vled_out #(
    .led_w       (led_w),
    .sync_stages (sync_stages)
  ) vled_out_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vdip            (vdip),
    .led_shadow      (led_shadow),
    .vled            (vled)
  );

endmodule

`default_nettype wire

// File: bench/tb_top.sv
// Directed AXI-Lite tests for cl_hello_top with 16-bit LEDs and counter; stops at the first error
`default_nettype none
`timescale 1ns/1ps

module tb_top;

  localparam int led_w       = 16;
  localparam int sync_stages = 2;
  localparam int cnt_w       = 16;
  // About four times the longest test sequence
  localparam int max_cycles  = 2000;
  localparam logic [31:0] addr_unmapped = 32'h0000_05F0;

  logic                clk_main_a0;
  logic                rst_main_n_sync;
  axil_pkg::axil_req_t ocl_req;
  axil_pkg::axil_rsp_t ocl_rsp;
  logic [led_w-1:0]    vdip;
  logic [led_w-1:0]    vled;

  integer              seed;
  int                  cycle_count;
  string               test_name;
  logic [31:0]         last_hello;

  cl_hello_top #(
    .led_w       (led_w),
    .sync_stages (sync_stages),
    .cnt_w       (cnt_w)
  ) dut_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_req         (ocl_req),
    .ocl_rsp         (ocl_rsp),
    .vdip            (vdip),
    .vled            (vled)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #4 clk_main_a0 = ~clk_main_a0;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk_main_a0);
      cycle_count++;
      if (cycle_count >= max_cycles) begin
        abort_run($sformatf("timeout after %0d cycles in %s, a handshake never completed",
                            cycle_count, test_name));
      end
    end
  end

  // ------------------------------
  // Reporting and reference model
  // ------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic expect_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else abort_run($sformatf("error %s %s: expected %08h, actual %08h",
                                                  test_name, what, exp, act));
  endtask

  task automatic expect_below(input string what, input logic [31:0] limit,
                              input logic [31:0] act);
    assert (act < limit) else abort_run($sformatf("error %s %s: expected below %08h, actual %08h",
                                                  test_name, what, limit, act));
  endtask

  // Byte i of the result is byte 3-i of the word
  function automatic logic [31:0] byte_swap(input logic [31:0] w);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = w[8*(3-i) +: 8];
    end
    return r;
  endfunction

  // ------------------------------
  // AXI-Lite master
  // ------------------------------
  // hold is the number of cycles bready stays low once bvalid is seen
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data, input int hold);
    int lat;
    @(posedge clk_main_a0);
    ocl_req.awvalid <= 1'b1;
    ocl_req.awaddr  <= addr;
    @(posedge clk_main_a0);
    while (!ocl_rsp.awready) @(posedge clk_main_a0);
    ocl_req.awvalid <= 1'b0;
    ocl_req.wvalid  <= 1'b1;
    ocl_req.wdata   <= data;
    @(posedge clk_main_a0);
    while (!ocl_rsp.wready) @(posedge clk_main_a0);
    ocl_req.wvalid <= 1'b0;
    ocl_req.bready <= (hold == 0);
    lat = 0;
    do begin
      @(posedge clk_main_a0);
      lat++;
    end while (!ocl_rsp.bvalid);
    expect_word("bvalid latency", 32'd1, lat);
    expect_word("bresp", axil_pkg::resp_okay, ocl_rsp.bresp);
    if (hold > 0) begin
      repeat (hold) begin
        @(posedge clk_main_a0);
        assert (ocl_rsp.bvalid && !ocl_rsp.awready)
          else abort_run("bvalid dropped or awready raised while bready was low");
      end
      ocl_req.bready <= 1'b1;
      @(posedge clk_main_a0);
    end
    ocl_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, input int hold, output logic [31:0] data);
    int lat;
    @(posedge clk_main_a0);
    ocl_req.arvalid <= 1'b1;
    ocl_req.araddr  <= addr;
    @(posedge clk_main_a0);
    while (!ocl_rsp.arready) @(posedge clk_main_a0);
    ocl_req.arvalid <= 1'b0;
    ocl_req.rready  <= (hold == 0);
    lat = 0;
    do begin
      @(posedge clk_main_a0);
      lat++;
    end while (!ocl_rsp.rvalid);
    expect_word("rvalid latency", 32'd2, lat);
    expect_word("rresp", axil_pkg::resp_okay, ocl_rsp.rresp);
    data = ocl_rsp.rdata;
    if (hold > 0) begin
      repeat (hold) begin
        @(posedge clk_main_a0);
        assert (ocl_rsp.rvalid && ocl_rsp.rdata === data && !ocl_rsp.arready)
          else abort_run("read response changed or arready raised while rready was low");
      end
      ocl_req.rready <= 1'b1;
      @(posedge clk_main_a0);
    end
    ocl_req.rready <= 1'b0;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic hello_swap_test();
    logic [31:0] word;
    logic [31:0] rdata;
    test_name = "hello_swap";
    repeat (4) begin
      word = $random(seed);
      axil_write(regmap_pkg::addr_hello, word, 0);
      last_hello = word;
      axil_read(regmap_pkg::addr_hello, 0, rdata);
      expect_word("hello readback", byte_swap(word), rdata);
    end
  endtask

  task automatic unmapped_test();
    logic [31:0] rdata;
    test_name = "unmapped";
    axil_read(addr_unmapped, 0, rdata);
    expect_word("unmapped read", 32'hDEAD_DEAD, rdata);
    axil_write(addr_unmapped, $random(seed), 0);
    axil_read(regmap_pkg::addr_hello, 0, rdata);
    expect_word("hello after unmapped write", byte_swap(last_hello), rdata);
    axil_read(regmap_pkg::addr_vled, 0, rdata);
    expect_word("vled shadow", {16'h0, last_hello[15:0]}, rdata);
  endtask

  task automatic vled_mask_test();
    logic [31:0] word;
    test_name = "vled_mask";
    word = 32'h1234_A5C3;
    @(posedge clk_main_a0);
    vdip <= 16'hF0F3;
    axil_write(regmap_pkg::addr_hello, word, 0);
    last_hello = word;
    repeat (sync_stages + 3) @(posedge clk_main_a0);
    expect_word("vled masked", {16'h0, word[15:0] & 16'hF0F3}, {16'h0, vled});
    vdip <= '0;
    repeat (sync_stages + 3) @(posedge clk_main_a0);
    expect_word("vled dip off", 32'h0, {16'h0, vled});
  endtask

  task automatic counter_load_clear_test();
    logic [31:0] rdata;
    test_name = "counter_load_clear";
    axil_write(regmap_pkg::addr_cnt_load, 32'h0000_1234, 0);
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'h4, 0);
    // Watermark is still zero, so the flag reads set
    axil_read(regmap_pkg::addr_cnt_status, 0, rdata);
    expect_word("status after load", 32'h0001_1234, rdata);
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'h8, 0);
    axil_read(regmap_pkg::addr_cnt_status, 0, rdata);
    expect_word("status after clear", 32'h0001_0000, rdata);
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'hE, 0);
    axil_read(regmap_pkg::addr_cnt_ctrl, 0, rdata);
    expect_word("ctrl readback", 32'h2, rdata);
  endtask

  task automatic counter_run_test();
    logic [31:0] rdata;
    test_name = "counter_run";
    axil_write(regmap_pkg::addr_cnt_tick, 32'h0, 0);
    axil_write(regmap_pkg::addr_cnt_load, 32'h0000_FFFE, 0);
    // Load, enable and one-shot together
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'h7, 0);
    repeat (20) @(posedge clk_main_a0);
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'h0, 0);
    axil_read(regmap_pkg::addr_cnt_status, 0, rdata);
    expect_word("one-shot saturates", 32'h0001_FFFF, rdata);
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'h5, 0);
    repeat (20) @(posedge clk_main_a0);
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'h0, 0);
    axil_read(regmap_pkg::addr_cnt_status, 0, rdata);
    expect_below("free-running wrap", 32'h20, {16'h0, rdata[15:0]});
    // Watermark below, then above, a held count
    axil_write(regmap_pkg::addr_cnt_load, 32'h0000_1000, 0);
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'h4, 0);
    axil_write(regmap_pkg::addr_cnt_mark, 32'h0000_0800, 0);
    axil_read(regmap_pkg::addr_cnt_status, 0, rdata);
    expect_word("mark below count", 32'h0001_1000, rdata);
    axil_write(regmap_pkg::addr_cnt_mark, 32'h0000_2000, 0);
    axil_read(regmap_pkg::addr_cnt_status, 0, rdata);
    expect_word("mark above count", 32'h0000_1000, rdata);
  endtask

  task automatic counter_tick_test();
    logic [31:0] rdata;
    test_name = "counter_tick";
    axil_write(regmap_pkg::addr_cnt_tick, 32'h3, 0);
    axil_read(regmap_pkg::addr_cnt_tick, 0, rdata);
    expect_word("tick readback", 32'h3, rdata);
    axil_read(regmap_pkg::addr_cnt_load, 0, rdata);
    expect_word("load readback", 32'h0000_1000, rdata);
    axil_read(regmap_pkg::addr_cnt_mark, 0, rdata);
    expect_word("mark readback", 32'h0000_2000, rdata);
    // Clear also zeroes the prescaler
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'h8, 0);
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'h1, 0);
    // Enable spans 42 run cycles for 10 counts
    repeat (38) @(posedge clk_main_a0);
    axil_write(regmap_pkg::addr_cnt_ctrl, 32'h0, 0);
    axil_read(regmap_pkg::addr_cnt_status, 0, rdata);
    expect_word("prescaled count", 32'h0000_000A, rdata);
  endtask

  task automatic backpressure_test();
    logic [31:0] word;
    logic [31:0] rdata;
    test_name = "backpressure";
    word = $random(seed);
    axil_write(regmap_pkg::addr_hello, word, 10);
    last_hello = word;
    axil_read(regmap_pkg::addr_hello, 10, rdata);
    expect_word("held read data", byte_swap(word), rdata);
  endtask

  initial begin
    seed            = 65;
    test_name       = "reset";
    last_hello      = '0;
    ocl_req         = '0;
    vdip            = '0;
    rst_main_n_sync = 1'b0;
    repeat (10) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    hello_swap_test();
    unmapped_test();
    vled_mask_test();
    counter_load_clear_test();
    counter_run_test();
    counter_tick_test();
    backpressure_test();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
common/axil_pkg.sv
common/regmap_pkg.sv
ocl_slave/ocl_slave.sv
verilog/reg_file.sv
verilog/vled_out.sv
tick_counter/tick_counter.sv
verilog/cl_hello_top.sv
bench/tb_top.sv
